/* bench/pcs_model.svh */
`ifndef PCS_MODEL_SVH
`define PCS_MODEL_SVH

logic [31:0]        lfsr_q = 32'hd8a653c7; // x^32+x^22+x^2+x+1, fibonacci form
logic [SCR_LEN-1:0] scr_in_q = '0;         // scrambler for the stimulus line
logic [SCR_LEN-1:0] dscr_out_q = '0;       // descrambler for the DUT output line
logic               lock_m = 1'b0;         // expected block lock
int                 good_run = 0;          // good headers in a row while hunting
int                 win_cnt = 0;           // blocks seen in this window
int                 bad_cnt = 0;           // bad headers in this window

function automatic logic [63:0] take_bits(input int n);
	logic [63:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
		r      = {r[62:0], lfsr_q[0]}; // one step per bit
	end
	return r;
endfunction

function automatic int take_int(input int n);
	return int'(take_bits(n));
endfunction

// x^58 + x^39 + 1, bit 0 of the payload goes first
function automatic payload_t scramble(input payload_t plain);
	payload_t line;
	for (int i = 0; i < PAYLOAD_W; i++) begin
		line[i]  = plain[i] ^ scr_in_q[38] ^ scr_in_q[57];
		scr_in_q = {scr_in_q[56:0], line[i]};
	end
	return line;
endfunction

function automatic payload_t descramble(input payload_t line);
	payload_t plain;
	for (int i = 0; i < PAYLOAD_W; i++) begin
		plain[i]   = line[i] ^ dscr_out_q[38] ^ dscr_out_q[57];
		dscr_out_q = {dscr_out_q[56:0], line[i]}; // fills from line bits only
	end
	return plain;
endfunction

function automatic block_t idle_block();
	block_t b;
	b.hdr     = SYNC_CTRL;
	b.payload = {{KEEP_W{CHAR_IDLE}}, BT_IDLE};
	return b;
endfunction

function automatic block_t error_block();
	block_t b;
	b.hdr     = SYNC_CTRL;
	b.payload = {{KEEP_W{CHAR_ERROR}}, BT_IDLE}; // what a bad block turns into
	return b;
endfunction

function automatic block_t data_block();
	block_t b;
	b.hdr     = SYNC_DATA;
	b.payload = take_bits(64);
	return b;
endfunction

function automatic block_t start_block();
	block_t b;
	b.hdr     = SYNC_CTRL;
	b.payload = {56'(take_bits(56)), BT_START}; // 7 data bytes in lanes 1..7
	return b;
endfunction

function automatic block_t term_block(input int n);
	block_t     b;
	logic [7:0] code;
	case (n)
		0: code = BT_TERM0;
		1: code = BT_TERM1;
		2: code = BT_TERM2;
		3: code = BT_TERM3;
		4: code = BT_TERM4;
		5: code = BT_TERM5;
		6: code = BT_TERM6;
		default: code = BT_TERM7;
	endcase
	b.hdr     = SYNC_CTRL;
	b.payload = {56'h0, code}; // idle chars after the data are all zero
	for (int k = 0; k < n; k++)
		b.payload[8 + 8*k +: 8] = 8'(take_bits(8));
	return b;
endfunction

function automatic block_t unknown_block();
	block_t     b;
	logic [7:0] t;
	t = 8'(take_bits(8));
	while (t inside {BT_IDLE, BT_START, BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
			BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7})
		t = t + 8'd1; // step off any known type
	b.hdr     = SYNC_CTRL;
	b.payload = {56'(take_bits(56)), t};
	return b;
endfunction

// lock rules, lock_m holds the state after this header
task automatic update_lock(input logic hdr_ok);
	if (!lock_m) begin
		good_run = hdr_ok ? good_run + 1 : 0;
		if (good_run == LOCK_GOOD_CNT) begin
			lock_m  = 1'b1;
			win_cnt = 0;
			bad_cnt = 0;
		end
	end else begin
		win_cnt++;
		if (!hdr_ok)
			bad_cnt++;
		if (bad_cnt == LOCK_BAD_LIMIT) begin
			lock_m   = 1'b0; // back to hunting
			good_run = 0;
		end else if (win_cnt == LOCK_WINDOW) begin
			win_cnt = 0;
			bad_cnt = 0;
		end
	end
endtask

`endif

/* bench/pcs_loopback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_loopback_tb
	import pcs_types_pkg::*;
	import pcs_code_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	localparam int LOCK_BLOCKS  = 80; // good headers sent to reach lock
	localparam int FRAMES       = 30; // frames per locked phase
	localparam int FRAME_MAX    = 12; // idles + bad + start + data + term, worst case
	localparam int MAX_GAP      = 3;  // gap cycles before a block
	localparam int BAD_RUN_MAX  = 40; // bad headers allowed to force unlock
	localparam int MAX_BLOCKS   = 2*LOCK_BLOCKS + 2*FRAMES*FRAME_MAX + BAD_RUN_MAX;
	localparam int CYCLE_LIMIT  = MAX_BLOCKS*(1 + MAX_GAP) + RESET_CYCLES + 100;

	logic   gx_rx_par_clk;
	logic   reset_i;
	block_t rx_block_i;
	logic   rx_block_v_i;
	block_t tx_block_o;
	logic   tx_block_v_o;
	logic   block_lock_o;
	logic   rx_err_o;

	logic   hist_v[3];    // [0] is the cycle driven last
	logic   hist_err[3];
	logic   hist_lock[3];
	block_t hist_blk[3];  // expected plain output block
	logic   out_synced = 1'b0;
	int     errors = 0;
	int     checks = 0;
	int     cycles = 0;

	`include "pcs_model.svh"

	pcs_loopback_top uut (
		.gx_rx_par_clk (gx_rx_par_clk),
		.reset_i       (reset_i),
		.rx_block_i    (rx_block_i),
		.rx_block_v_i  (rx_block_v_i),
		.tx_block_o    (tx_block_o),
		.tx_block_v_o  (tx_block_v_o),
		.block_lock_o  (block_lock_o),
		.rx_err_o      (rx_err_o)
	);

	initial begin
		gx_rx_par_clk = 1'b0;
		forever #50 gx_rx_par_clk = ~gx_rx_par_clk;
	end

	always @(posedge gx_rx_par_clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, stimulus never finished", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// lock 1 cycle, rx_err 2 cycles, block 3 cycles behind the input
	task automatic check_outputs();
		payload_t got;
		checks++;
		if (block_lock_o !== hist_lock[0]) begin
			errors++;
			$display("Error: block_lock_o %h, expected %h", block_lock_o, hist_lock[0]);
		end
		if (rx_err_o !== hist_err[1]) begin
			errors++;
			$display("Error: rx_err_o %h, expected %h", rx_err_o, hist_err[1]);
		end
		if (tx_block_v_o !== hist_v[2]) begin
			errors++;
			$display("Error: tx_block_v_o %h, expected %h", tx_block_v_o, hist_v[2]);
		end
		if (tx_block_v_o === 1'b1) begin
			got = descramble(tx_block_o.payload); // keep in step with the line
			if (out_synced && hist_v[2] &&
					(tx_block_o.hdr !== hist_blk[2].hdr || got !== hist_blk[2].payload)) begin
				errors++;
				$display("Error: tx_block_o %h_%h descrambled, expected %h_%h",
					tx_block_o.hdr, got, hist_blk[2].hdr, hist_blk[2].payload);
			end
			out_synced = 1'b1; // first block only fills the descrambler
		end
	endtask

	task automatic tick(input logic v, input block_t plain, input logic bad);
		block_t line;
		logic   hdr_ok;
		@(negedge gx_rx_par_clk);
		check_outputs();
		line   = plain;
		hdr_ok = (plain.hdr == SYNC_DATA) || (plain.hdr == SYNC_CTRL);
		if (v) begin
			line.payload = scramble(plain.payload);
			update_lock(hdr_ok);
		end else begin
			line.payload = take_bits(64); // junk while the gearbox gaps
		end
		for (int k = 2; k > 0; k--) begin
			hist_v[k]    = hist_v[k-1];
			hist_err[k]  = hist_err[k-1];
			hist_lock[k] = hist_lock[k-1];
			hist_blk[k]  = hist_blk[k-1];
		end
		hist_v[0]    = v;
		hist_err[0]  = v && lock_m && bad;
		hist_lock[0] = lock_m;
		hist_blk[0]  = !lock_m ? idle_block() : (bad ? error_block() : plain);
		rx_block_i   = line;
		rx_block_v_i = v;
	endtask

	task automatic send(input block_t plain, input logic bad);
		int gap;
		gap = 0;
		if (take_int(2) == 0)
			gap = take_int(2) % MAX_GAP + 1; // about one block in four
		repeat (gap) tick(1'b0, plain, 1'b0);
		tick(1'b1, plain, bad);
	endtask

	task automatic send_bad(input logic hdr_only);
		block_t b;
		if (hdr_only || take_int(1) != 0) begin
			b     = take_int(1) != 0 ? data_block() : idle_block();
			b.hdr = take_int(1) != 0 ? 2'b00 : 2'b11;
		end else begin
			b = unknown_block();
		end
		send(b, 1'b1);
	endtask

	task automatic send_frame();
		int idles;
		int n_data;
		idles  = take_int(2) + 1;
		n_data = take_int(3) % 6;
		repeat (idles) send(idle_block(), 1'b0);
		if (take_int(2) == 0)
			send_bad(1'b0); // sparse, stays far below the unlock limit
		send(start_block(), 1'b0);
		repeat (n_data) send(data_block(), 1'b0);
		send(term_block(take_int(3)), 1'b0);
	endtask

	initial begin
		int n_bad;
		reset_i      = 1'b1;
		rx_block_v_i = 1'b0;
		rx_block_i   = '0;
		for (int k = 0; k < 3; k++) begin
			hist_v[k]    = 1'b0;
			hist_err[k]  = 1'b0;
			hist_lock[k] = 1'b0;
			hist_blk[k]  = '0;
		end
		repeat (RESET_CYCLES) tick(1'b0, idle_block(), 1'b0);
		reset_i = 1'b0;

		repeat (LOCK_BLOCKS) send(take_int(1) != 0 ? data_block() : idle_block(), 1'b0);
		repeat (FRAMES) send_frame();

		n_bad = 0;
		while (lock_m && n_bad < BAD_RUN_MAX) begin
			send_bad(1'b1);
			n_bad++;
		end
		if (lock_m) begin
			errors++;
			$display("lock was still expected after %0d bad headers in a row", n_bad);
		end

		// hunt again, data blocks must come out as idle until lock
		repeat (LOCK_BLOCKS) send(take_int(1) != 0 ? data_block() : idle_block(), 1'b0);
		repeat (FRAMES) send_frame();
		repeat (4) tick(1'b0, idle_block(), 1'b0);   // drain the pipeline

		$display("%0d cycles checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* pcs_loopback.f */
+incdir+bench
rtl/pcs_types_pkg.sv
rtl/pcs_code_pkg.sv
rtl/pcs_block_lock.sv
rtl/pcs_rx_decode.sv
rtl/pcs_loopback.sv
rtl/pcs_tx_encode.sv
rtl/pcs_loopback_top.sv
bench/pcs_loopback_tb.sv

/* rtl/pcs_block_lock.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_block_lock
	import pcs_types_pkg::*;
	import pcs_code_pkg::*;
(
	input  wire            gx_rx_par_clk,
	input  wire            reset_i,
	input  wire sync_hdr_t sync_hdr_i,
	input  wire            hdr_v_i,
	output logic           lock_o
);

	lock_state_e           state_q;
	logic [LOCK_CNT_W-1:0] good_cnt_q; // good headers in a row while hunting
	logic [LOCK_CNT_W-1:0] win_cnt_q;  // position inside the window
	logic [LOCK_CNT_W-1:0] bad_cnt_q;  // bad headers in this window
	logic                  hdr_ok;

	assign hdr_ok = (sync_hdr_i == SYNC_DATA) || (sync_hdr_i == SYNC_CTRL); // 00/11 invalid

	always_ff @(posedge gx_rx_par_clk) begin
		if (reset_i) begin
			state_q    <= ST_HUNT;
			good_cnt_q <= '0;
			win_cnt_q  <= '0;
			bad_cnt_q  <= '0;
		end else if (hdr_v_i) begin // gaps leave everything alone
			case (state_q)
				ST_HUNT: begin
					if (!hdr_ok) begin
						good_cnt_q <= '0; // start over
					end else if (good_cnt_q == LOCK_CNT_W'(LOCK_GOOD_CNT - 1)) begin
						state_q    <= ST_LOCKED; // this is the 64th
						good_cnt_q <= '0;
						win_cnt_q  <= '0;
						bad_cnt_q  <= '0;
					end else begin
						good_cnt_q <= good_cnt_q + 1'b1;
					end
				end
				ST_LOCKED: begin
					if (!hdr_ok && bad_cnt_q == LOCK_CNT_W'(LOCK_BAD_LIMIT - 1)) begin
						state_q    <= ST_HUNT; // 16th bad one in the window
						good_cnt_q <= '0;
					end else if (win_cnt_q == LOCK_CNT_W'(LOCK_WINDOW - 1)) begin
						win_cnt_q <= '0; // window closes, fresh count
						bad_cnt_q <= '0;
					end else begin
						win_cnt_q <= win_cnt_q + 1'b1;
						bad_cnt_q <= bad_cnt_q + LOCK_CNT_W'(!hdr_ok);
					end
				end
				default: state_q <= ST_HUNT;
			endcase
		end
	end

	assign lock_o = (state_q == ST_LOCKED);

	// state only moves on a valid header
	lock_rise_after_valid: assert property (@(posedge gx_rx_par_clk) disable iff (reset_i)
		$rose(lock_o) |-> $past(hdr_v_i));

endmodule

`default_nettype wire

/* rtl/pcs_code_pkg.sv */
`default_nettype none

package pcs_code_pkg;
	import pcs_types_pkg::*;

	localparam sync_hdr_t SYNC_DATA = 2'b01; // 8 data bytes follow
	localparam sync_hdr_t SYNC_CTRL = 2'b10; // type byte + control payload

	localparam int CHAR_W = 7; // control character width

	localparam logic [7:0] BT_IDLE  = 8'h1e; // 8 control characters
	localparam logic [7:0] BT_START = 8'h78; // start in lane 0, 7 data bytes
	localparam logic [7:0] BT_TERM0 = 8'h87; // terminate after 0 data bytes
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'haa;
	localparam logic [7:0] BT_TERM3 = 8'hb4;
	localparam logic [7:0] BT_TERM4 = 8'hcc;
	localparam logic [7:0] BT_TERM5 = 8'hd2;
	localparam logic [7:0] BT_TERM6 = 8'he1;
	localparam logic [7:0] BT_TERM7 = 8'hff; // terminate after 7 data bytes

	localparam logic [CHAR_W-1:0] CHAR_IDLE  = 7'h00;
	localparam logic [CHAR_W-1:0] CHAR_ERROR = 7'h1e;

	localparam int LOCK_GOOD_CNT  = 64; // consecutive good headers to lock
	localparam int LOCK_BAD_LIMIT = 16; // bad headers per window to unlock
	localparam int LOCK_WINDOW    = 64; // blocks per window
	localparam int LOCK_CNT_W     = 7;  // holds up to 64

	localparam int SCR_LEN = 58; // x^58 term, state width
	localparam int SCR_TAP = 39; // x^39 term

	typedef enum logic {
		ST_HUNT,   // looking for 64 good headers in a row
		ST_LOCKED  // counting bad headers per window
	} lock_state_e;

endpackage

`default_nettype wire

/* rtl/pcs_loopback.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_loopback
	import pcs_types_pkg::*;
(
	input  wire            gx_rx_par_clk,
	input  wire            reset_i,
	input  wire pcs_word_t word_i,
	input  wire            word_v_i,
	input  wire            lock_i,
	output pcs_word_t      word_o,
	output logic           word_v_o,
	output logic           rx_err_o
);

	always_ff @(posedge gx_rx_par_clk) begin
		if (reset_i) begin
			word_v_o <= 1'b0;
			rx_err_o <= 1'b0;
		end else begin
			word_v_o <= word_v_i;                        // gaps pass straight on
			rx_err_o <= word_v_i && lock_i && word_i.err; // single cycle per bad word
		end
	end

	// data side of the stage toward transmit
	always_ff @(posedge gx_rx_par_clk) begin
		if (word_v_i)
			word_o <= lock_i ? word_i : WORD_IDLE; // no lock, send idle
	end

	// lock_i and the word arrive together from lock and decode
	idle_when_unlocked: assert property (@(posedge gx_rx_par_clk) disable iff (reset_i)
		word_v_o && !$past(lock_i) |-> word_o == WORD_IDLE);

endmodule

`default_nettype wire

/* rtl/pcs_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_loopback_top
	import pcs_types_pkg::*;
(
	input  wire         gx_rx_par_clk,
	input  wire         reset_i,
	input  wire block_t rx_block_i,   // block aligned from the transceiver
	input  wire         rx_block_v_i, // low on gearbox gaps
	output wire block_t tx_block_o,
	output wire         tx_block_v_o,
	output wire         block_lock_o,
	output wire         rx_err_o
);

	logic      lock;     // from the header counter
	pcs_word_t dec_word; // receive side result
	logic      dec_v;
	pcs_word_t lb_word;  // toward transmit
	logic      lb_v;

	pcs_block_lock m_block_lock (
		.gx_rx_par_clk (gx_rx_par_clk),
		.reset_i       (reset_i),
		.sync_hdr_i    (rx_block_i.hdr),
		.hdr_v_i       (rx_block_v_i),
		.lock_o        (lock)
	);

	pcs_rx_decode m_rx_decode (
		.gx_rx_par_clk (gx_rx_par_clk),
		.reset_i       (reset_i),
		.block_i       (rx_block_i),
		.block_v_i     (rx_block_v_i),
		.word_o        (dec_word),
		.word_v_o      (dec_v)
	);

	pcs_loopback m_loopback (
		.gx_rx_par_clk (gx_rx_par_clk),
		.reset_i       (reset_i),
		.word_i        (dec_word),
		.word_v_i      (dec_v),
		.lock_i        (lock), // lines up with dec_word
		.word_o        (lb_word),
		.word_v_o      (lb_v),
		.rx_err_o      (rx_err_o)
	);

	pcs_tx_encode m_tx_encode (
		.gx_rx_par_clk (gx_rx_par_clk), // tx shares the recovered clock
		.reset_i       (reset_i),
		.word_i        (lb_word),
		.word_v_i      (lb_v),
		.block_o       (tx_block_o),
		.block_v_o     (tx_block_v_o)
	);

	assign block_lock_o = lock;

endmodule

`default_nettype wire

/* rtl/pcs_rx_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_decode
	import pcs_types_pkg::*;
	import pcs_code_pkg::*;
(
	input  wire         gx_rx_par_clk,
	input  wire         reset_i,
	input  wire block_t block_i,
	input  wire         block_v_i,
	output pcs_word_t   word_o,
	output logic        word_v_o
);

	logic [SCR_LEN-1:0] dscr_q;    // received scrambled bits, [0] newest
	logic [SCR_LEN-1:0] dscr_d;
	payload_t           plain;     // descrambled payload
	payload_t           lane_data; // control payload moved down to lane 0
	payload_t           term_mask;
	keep_t              term_keep;
	logic               term_hit;
	logic               chars_idle;
	pcs_word_t          dec;

	// self-synchronising, state fills from the line bits only
	always_comb begin : descramble
		logic [SCR_LEN-1:0] s;
		s = dscr_q;
		for (int i = 0; i < PAYLOAD_W; i++) begin
			plain[i] = block_i.payload[i] ^ s[SCR_TAP-1] ^ s[SCR_LEN-1];
			s        = {s[SCR_LEN-2:0], block_i.payload[i]}; // lsb goes first on the line
		end
		dscr_d = s;
	end

	always_comb begin : decode
		lane_data  = {8'h00, plain[PAYLOAD_W-1:8]}; // drop type byte
		chars_idle = 1'b1;
		for (int k = 0; k < KEEP_W; k++) begin
			if (plain[8 + CHAR_W*k +: CHAR_W] != CHAR_IDLE)
				chars_idle = 1'b0; // any other char, error char included
		end

		term_hit = 1'b1;
		case (plain[7:0])
			BT_TERM0: term_keep = 8'h00;
			BT_TERM1: term_keep = 8'h01;
			BT_TERM2: term_keep = 8'h03;
			BT_TERM3: term_keep = 8'h07;
			BT_TERM4: term_keep = 8'h0f;
			BT_TERM5: term_keep = 8'h1f;
			BT_TERM6: term_keep = 8'h3f;
			BT_TERM7: term_keep = 8'h7f;
			default: begin
				term_hit  = 1'b0;
				term_keep = '0;
			end
		endcase
		for (int k = 0; k < KEEP_W; k++)
			term_mask[8*k +: 8] = {8{term_keep[k]}}; // clear bytes past the end

		dec      = '0;
		dec.ctrl = (block_i.hdr != SYNC_DATA); // bad headers count as control
		if (block_i.hdr == SYNC_DATA) begin
			dec.keep = '1;
			dec.data = plain;
		end else if (block_i.hdr != SYNC_CTRL) begin
			dec.err = 1'b1;
		end else if (plain[7:0] == BT_IDLE) begin
			dec.idle = chars_idle;
			dec.err  = !chars_idle;
		end else if (plain[7:0] == BT_START) begin
			dec.start = 1'b1;
			dec.keep  = 8'h7f; // 7 data bytes after start
			dec.data  = lane_data;
		end else if (term_hit) begin
			dec.term = 1'b1;
			dec.keep = term_keep;
			dec.data = lane_data & term_mask;
		end else begin
			dec.err = 1'b1; // unknown type byte
		end
	end

	always_ff @(posedge gx_rx_par_clk) begin
		if (reset_i) begin
			dscr_q   <= '0;
			word_v_o <= 1'b0;
		end else begin
			word_v_o <= block_v_i;
			if (block_v_i)
				dscr_q <= dscr_d; // hold across gaps
		end
	end

	always_ff @(posedge gx_rx_par_clk) begin
		if (block_v_i)
			word_o <= dec;
	end

	dec_kind_onehot: assert property (@(posedge gx_rx_par_clk) disable iff (reset_i)
		word_v_o |-> $onehot0({word_o.idle, word_o.start, word_o.term}));

endmodule

`default_nettype wire

/* rtl/pcs_tx_encode.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_tx_encode
	import pcs_types_pkg::*;
	import pcs_code_pkg::*;
(
	input  wire            gx_rx_par_clk,
	input  wire            reset_i,
	input  wire pcs_word_t word_i,
	input  wire            word_v_i,
	output block_t         block_o,
	output logic           block_v_o
);

	logic [SCR_LEN-1:0]     scr_q;      // sent scrambled bits, [0] newest
	logic [SCR_LEN-1:0]     scr_d;
	block_t                 plain;      // block before scrambling
	payload_t               scrambled;
	logic [PAYLOAD_W-9:0]   term_lanes; // lanes 1..7 of a terminate block
	logic [7:0]             term_code;
	logic                   term_ok;

	always_comb begin : build
		for (int k = 0; k < KEEP_W-1; k++)
			term_lanes[8*k +: 8] = word_i.keep[k] ? word_i.data[8*k +: 8] : {1'b0, CHAR_IDLE};

		term_ok = 1'b1;
		case (word_i.keep)
			8'h00: term_code = BT_TERM0;
			8'h01: term_code = BT_TERM1;
			8'h03: term_code = BT_TERM2;
			8'h07: term_code = BT_TERM3;
			8'h0f: term_code = BT_TERM4;
			8'h1f: term_code = BT_TERM5;
			8'h3f: term_code = BT_TERM6;
			8'h7f: term_code = BT_TERM7;
			default: begin
				term_ok   = 1'b0; // holes in keep, sent as error
				term_code = BT_IDLE;
			end
		endcase

		plain.hdr     = SYNC_CTRL;
		plain.payload = {{KEEP_W{CHAR_IDLE}}, BT_IDLE}; // idle is the fallback
		if (word_i.err || (word_i.ctrl && word_i.term && !term_ok)) begin
			plain.payload = {{KEEP_W{CHAR_ERROR}}, BT_IDLE};
		end else if (!word_i.ctrl) begin
			plain.hdr     = SYNC_DATA;
			plain.payload = word_i.data;
		end else if (word_i.start) begin
			plain.payload = {word_i.data[PAYLOAD_W-9:0], BT_START}; // bytes 0..6 in lanes 1..7
		end else if (word_i.term) begin
			plain.payload = {term_lanes, term_code};
		end
	end

	always_comb begin : scramble
		logic [SCR_LEN-1:0] s;
		s = scr_q;
		for (int i = 0; i < PAYLOAD_W; i++) begin
			scrambled[i] = plain.payload[i] ^ s[SCR_TAP-1] ^ s[SCR_LEN-1];
			s            = {s[SCR_LEN-2:0], scrambled[i]}; // feed back what goes out
		end
		scr_d = s;
	end

	always_ff @(posedge gx_rx_par_clk) begin
		if (reset_i) begin
			scr_q     <= '0;
			block_v_o <= 1'b0;
		end else begin
			block_v_o <= word_v_i;
			if (word_v_i)
				scr_q <= scr_d; // state frozen on gaps
		end
	end

	always_ff @(posedge gx_rx_par_clk) begin
		if (word_v_i) begin
			block_o.hdr     <= plain.hdr; // header goes out in clear
			block_o.payload <= scrambled;
		end
	end

	// decode only builds keep from the terminate code
	term_keep_contig: assert property (@(posedge gx_rx_par_clk) disable iff (reset_i)
		word_v_i && word_i.ctrl && word_i.term && !word_i.err
		|-> (word_i.keep & keep_t'(word_i.keep + 1'b1)) == '0);

endmodule

`default_nettype wire

/* rtl/pcs_types_pkg.sv */
`default_nettype none

package pcs_types_pkg;

	localparam int HDR_W     = 2;             // sync header bits
	localparam int PAYLOAD_W = 64;            // scrambled part of a block
	localparam int KEEP_W    = PAYLOAD_W / 8; // one bit per byte lane

	typedef logic [HDR_W-1:0]     sync_hdr_t;
	typedef logic [PAYLOAD_W-1:0] payload_t;
	typedef logic [KEEP_W-1:0]    keep_t;    // lane 0 in bit 0

	typedef struct packed {
		payload_t  payload; // type byte in [7:0] on control blocks
		sync_hdr_t hdr;     // first on the line, never scrambled
	} block_t;

	typedef struct packed {
		logic     ctrl;  // control block
		logic     idle;  // all idle characters
		logic     start; // frame starts in lane 0
		logic     term;  // terminate, keep gives bytes before it
		logic     err;   // bad header, bad type or error characters
		keep_t    keep;
		payload_t data;  // data bytes in lane order
	} pcs_word_t;

	// substituted on the transmit side while out of lock
	localparam pcs_word_t WORD_IDLE = '{
		ctrl: 1'b1, idle: 1'b1, start: 1'b0, term: 1'b0, err: 1'b0,
		keep: '0, data: '0
	};

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the PCS loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f pcs_loopback.f \
	--top-module pcs_loopback_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$OBJ/Vpcs_loopback_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation passed"
exit 0
